// ==== verilog/pBusPkg.sv ====
package pBusPkg;

	localparam int SLOT_W = 4;     // 16 master clocks per P bus frame
	localparam int PBUS_W = 24;    // Shared P bus width

	// Slot numbers within one frame
	// Slots with no name here are idle slots
	typedef enum logic [SLOT_W-1:0]
	{
		SLOT_CADDR   = 4'd0,     // Sprite graphics ROM address
		SLOT_VCS_ON  = 4'd2,     // nVCS falls after this slot
		SLOT_L0ADDR  = 4'd3,     // L0 ROM address, upper byte released
		SLOT_SADDR   = 4'd7,     // Fix ROM address
		SLOT_SPRPAL  = 4'd10,    // Sprite palette and X position
		SLOT_VCS_OFF = 4'd12,    // nVCS rises after this slot
		SLOT_FIXPAL  = 4'd13,    // Fix palette, B1 latch point
		SLOT_LAST    = 4'd15     // LOAD strobe
	} pSlot_e;

	// Sprite side request, sampled in its own slots
	typedef struct packed
	{
		logic [24:0] cRomAddr;   // CA0 stays inside the chip
		logic [7:0]  sprPal;
		logic [7:0]  sprXpos;
		logic [15:0] l0RomAddr;
	} spriteReq_t;

	// Fix layer request
	typedef struct packed
	{
		logic [15:0] sRomAddr;
		logic [3:0]  fixPal;
	} fixReq_t;

	// Fix pixel pair as held by the B1 latch
	typedef struct packed
	{
		logic [3:0] fixPal;
		logic [3:0] pixLeft;     // Low nibble of the ROM byte
		logic [3:0] pixRight;    // High nibble
	} fixOut_t;

endpackage

// ==== verilog/pCycle.sv ====
`timescale 1ns/1ps

module pCycle import pBusPkg::*;
(
	input  logic   CLK_24M,
	input  logic   nRESET,
	output pSlot_e slot,
	output logic   s1h1,
	output logic   load,
	output logic   nVcs
);

	logic [SLOT_W-1:0] slotCnt;    // Free-running frame position

	// Master slot counter
	// Held at 0 in reset and for the first cycle after release
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slotCnt <= '0;
		else
			slotCnt <= slotCnt + 1'b1;    // Wraps 15 -> 0 on its own
	end

	assign slot = pSlot_e'(slotCnt);

	// Half-frame square wave for the fix pixel pair select
	assign s1h1 = slotCnt[SLOT_W-1];

	// One slot wide, end of frame
	assign load = (slot == SLOT_LAST);

	// Video RAM chip select
	// Registered so it moves one cycle after the decoding slot
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			nVcs <= 1'b1;    // Deselected out of reset
		else if (slot == SLOT_VCS_ON)
			nVcs <= 1'b0;    // Low from slot 3
		else if (slot == SLOT_VCS_OFF)
			nVcs <= 1'b1;    // High again from slot 13
	end

	// nVcs mirrors the slot one cycle back
	// Low exactly for previous slots 2 through 11
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!nVcs == (($past(slot) >= SLOT_VCS_ON) && ($past(slot) < SLOT_VCS_OFF)))
	else
		$error("nVcs out of step with slot %0d", $past(slot));

endmodule

// ==== verilog/pBusMux.sv ====
`timescale 1ns/1ps

module pBusMux import pBusPkg::*;
#(
	parameter int ROM_LATENCY = 2    // Slots from L0 address to data capture
)
(
	input  logic              CLK_24M,
	input  logic              nRESET,
	input  pSlot_e            slot,
	input  spriteReq_t        spriteReq,
	input  fixReq_t           fixReq,
	inout  wire  [PBUS_W-1:0] pBus,
	output logic [7:0]        l0Data
);

	// Last slot of the L0 read window, data sampled at its end
	localparam int CAPTURE_SLOT = int'(SLOT_L0ADDR) + ROM_LATENCY;

	logic [PBUS_W-1:0] busWord;    // Value for the current slot
	logic              upperEn;    // Chip owns bits 23..16
	logic              l0Window;   // L0 ROM read in progress

	// Only 1 to 3 fits before the fix address slot
	if ((ROM_LATENCY < 1) || (ROM_LATENCY > 3))
	begin : gBadLatency
		$error("ROM_LATENCY %0d outside 1..3", ROM_LATENCY);
	end

	// Slot word select
	always_comb
	begin
		busWord = '0;    // Idle slots put zero on the bus
		case (slot)
			SLOT_CADDR:
				busWord = spriteReq.cRomAddr[24:1];    // Word address
			SLOT_L0ADDR:
				busWord = {8'h00, spriteReq.l0RomAddr};    // Upper byte released anyway
			SLOT_SADDR:
				busWord = {8'h00, fixReq.sRomAddr};
			SLOT_SPRPAL:
				busWord = {spriteReq.sprPal, spriteReq.sprXpos, 8'h00};
			SLOT_FIXPAL:
				busWord = {4'h0, fixReq.fixPal, 16'h0000};    // Palette on 19..16
			default:
				busWord = '0;
		endcase
	end

	// L0 ROM answers on the upper byte from the address slot
	// until the capture slot
	assign l0Window = (slot >= SLOT_L0ADDR) && (int'(slot) <= CAPTURE_SLOT);

	// Upper byte also floats during the fix address
	assign upperEn = !(l0Window || (slot == SLOT_SADDR));

	assign pBus[15:0]  = busWord[15:0];    // Lower part always driven
	assign pBus[23:16] = upperEn ? busWord[23:16] : 8'hzz;

	// L0 data capture
	// Held for a full frame until the next read
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			l0Data <= '0;
		else if (int'(slot) == CAPTURE_SLOT)
			l0Data <= pBus[23:16];
	end

	// Captured byte must come from the ROM and hold no X
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		(int'(slot) == CAPTURE_SLOT) |-> !$isunknown(pBus[23:16]))
	else
		$error("L0 data unknown at capture slot");

endmodule

// ==== verilog/fixPixelLatch.sv ====
`timescale 1ns/1ps

module fixPixelLatch import pBusPkg::*;
(
	input  logic       CLK_24M,
	input  logic       nRESET,
	input  pSlot_e     slot,
	input  fixReq_t    fixReq,
	input  logic [7:0] fixData,
	output fixOut_t    fixOut
);

	fixOut_t nextOut;    // Pixel pair as it will be latched
	logic    latchEn;    // B1 latch point

	assign latchEn = (slot == SLOT_FIXPAL);

	// One ROM byte carries two 4-bit pixels
	// Left pixel comes from the low nibble
	always_comb
	begin
		nextOut.fixPal   = fixReq.fixPal;     // Palette on the bus this slot
		nextOut.pixLeft  = fixData[3:0];
		nextOut.pixRight = fixData[7:4];
	end

	// B1 style latch
	// ROM data has settled since the fix address slot
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			fixOut <= '0;
		else if (latchEn)
			fixOut <= nextOut;    // Visible from slot 14
	end

	// Pair is stable for the rest of the frame
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$changed(fixOut) |-> ($past(slot) == SLOT_FIXPAL))
	else
		$error("Fix pixel pair changed outside the latch slot");

endmodule

// ==== verilog/pBusTop.sv ====
`timescale 1ns/1ps

module pBusTop import pBusPkg::*;
#(
	parameter int ROM_LATENCY = 2    // L0 ROM access time in slots
)
(
	input  logic              CLK_24M,
	input  logic              nRESET,
	input  spriteReq_t        spriteReq,
	input  fixReq_t           fixReq,
	input  logic [7:0]        fixData,    // Fix ROM byte
	inout  wire  [PBUS_W-1:0] pBus,
	output logic              s1h1,
	output logic              load,
	output logic              nVcs,
	output logic [7:0]        l0Data,
	output fixOut_t           fixOut
);

	pSlot_e slot;    // Shared frame position

	// Slot counter and strobes
	pCycle uCycle
	(
		.CLK_24M (CLK_24M),
		.nRESET  (nRESET),
		.slot    (slot),
		.s1h1    (s1h1),
		.load    (load),
		.nVcs    (nVcs)
	);

	// P bus driver and L0 readback
	pBusMux #(
		.ROM_LATENCY (ROM_LATENCY)
	) uBusMux
	(
		.CLK_24M   (CLK_24M),
		.nRESET    (nRESET),
		.slot      (slot),
		.spriteReq (spriteReq),
		.fixReq    (fixReq),
		.pBus      (pBus),
		.l0Data    (l0Data)
	);

	// Fix pixel pair
	fixPixelLatch uFixLatch
	(
		.CLK_24M (CLK_24M),
		.nRESET  (nRESET),
		.slot    (slot),
		.fixReq  (fixReq),
		.fixData (fixData),
		.fixOut  (fixOut)
	);

endmodule

// ==== dv/pBusRomModel.sv ====
`timescale 1ns/1ps

module pBusRomModel import pBusPkg::*;
#(
	parameter int ROM_LATENCY = 2    // Same access time as the DUT
)
(
	input  logic              CLK_24M,
	input  logic              nRESET,
	inout  wire  [PBUS_W-1:0] pBus,
	output logic [7:0]        fixData    // Fix ROM byte
);

	logic [SLOT_W-1:0] slotCnt;    // Follows the chip's frame position
	logic [15:0]       l0Addr;     // Held after the L0 address slot
	logic [7:0]        romByte;
	logic              romOe;      // Model owns the upper byte

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slotCnt <= '0;
		else
			slotCnt <= slotCnt + 1'b1;
	end

	// L0 address is only on the bus for one slot
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			l0Addr <= '0;
		else if (slotCnt == SLOT_L0ADDR)
			l0Addr <= pBus[15:0];
	end

	// Fix ROM content made up from the address
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			fixData <= '0;
		else if (slotCnt == SLOT_SADDR)
			fixData <= pBus[15:8] + pBus[7:0];    // Ready well before slot 13
	end

	// Address slot answers straight from the bus
	assign romByte = (slotCnt == SLOT_L0ADDR) ? (pBus[7:0] ^ 8'hA5) : (l0Addr[7:0] ^ 8'hA5);

	assign romOe = ((int'(slotCnt) >= int'(SLOT_L0ADDR))
		&& (int'(slotCnt) <= int'(SLOT_L0ADDR) + ROM_LATENCY))
		|| (slotCnt == SLOT_SADDR);

	assign pBus[23:16] = romOe ? romByte : 8'hzz;    // Lower bits belong to the chip

endmodule

// ==== dv/pBusTb.sv ====
`timescale 1ns/1ps

module pBusTb import pBusPkg::*;
;

	localparam int ROM_LAT = 2;
	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 6;
	localparam int MAX_FRAMES = 20;    // Per test
	localparam int LIMIT_NS = NUM_TESTS * MAX_FRAMES * 16 * CLK_PERIOD + 20 * CLK_PERIOD;

	logic        CLK_24M = 1'b0;
	logic        nRESET;
	spriteReq_t  spriteReq;
	fixReq_t     fixReq;
	logic [7:0]  fixData;
	wire  [23:0] pBus;
	logic        s1h1;
	logic        load;
	logic        nVcs;
	logic [7:0]  l0Data;
	fixOut_t     fixOut;

	logic [3:0]  tbSlot;       // Own frame position
	logic [7:0]  fixAt13;      // fixData as seen in the latch slot
	int          errCount = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          startErrs;

	always #(CLK_PERIOD / 2) CLK_24M = ~CLK_24M;

	pBusTop #(
		.ROM_LATENCY (ROM_LAT)
	) dut0
	(
		.CLK_24M   (CLK_24M),
		.nRESET    (nRESET),
		.spriteReq (spriteReq),
		.fixReq    (fixReq),
		.fixData   (fixData),
		.pBus      (pBus),
		.s1h1      (s1h1),
		.load      (load),
		.nVcs      (nVcs),
		.l0Data    (l0Data),
		.fixOut    (fixOut)
	);

	pBusRomModel #(
		.ROM_LATENCY (ROM_LAT)
	) uRom
	(
		.CLK_24M (CLK_24M),
		.nRESET  (nRESET),
		.pBus    (pBus),
		.fixData (fixData)
	);

	always @(posedge CLK_24M)
	begin
		if (!nRESET)
			tbSlot <= '0;
		else
			tbSlot <= tbSlot + 1'b1;
		if (tbSlot == 4'd13)
			fixAt13 <= fixData;    // Byte the B1 latch should take
	end

	// Expected bus word per the slot table
	function automatic logic [23:0] scheduleWord(input logic [3:0] s, input spriteReq_t sr,
		input fixReq_t fr);
		logic [23:0] w;
		w = '0;
		if (s == SLOT_CADDR)
			w = sr.cRomAddr[24:1];
		else if (s == SLOT_L0ADDR)
			w[15:0] = sr.l0RomAddr;
		else if (s == SLOT_SADDR)
			w[15:0] = fr.sRomAddr;
		else if (s == SLOT_SPRPAL)
		begin
			w[23:16] = sr.sprPal;
			w[15:8]  = sr.sprXpos;
		end
		else if (s == SLOT_FIXPAL)
			w[19:16] = fr.fixPal;
		return w;
	endfunction

	// Slots where the ROM owns the upper byte
	function automatic logic romSlot(input logic [3:0] s);
		return ((s >= 4'd3) && (int'(s) <= 3 + ROM_LAT)) || (s == 4'd7);
	endfunction

	task automatic reportError(input string msg);
		errCount++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	assert property (@(posedge CLK_24M) $rose(nRESET) |->
		(nVcs && !load && (l0Data == 8'h00) && (fixOut == '0)))
	else
		reportError("state not cleared in first cycle after reset");

	assert property (@(posedge CLK_24M) disable iff (!nRESET) s1h1 == tbSlot[3])
	else
		reportError($sformatf("s1h1 %b in slot %0d", $sampled(s1h1), $sampled(tbSlot)));

	assert property (@(posedge CLK_24M) disable iff (!nRESET) load == (tbSlot == 4'd15))
	else
		reportError($sformatf("load %b in slot %0d", $sampled(load), $sampled(tbSlot)));

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		nVcs == !((tbSlot >= 4'd3) && (tbSlot <= 4'd12)))
	else
		reportError($sformatf("nVcs %b in slot %0d", $sampled(nVcs), $sampled(tbSlot)));

	// Lower 16 bits always belong to the chip
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		pBus[15:0] == 16'(scheduleWord(tbSlot, spriteReq, fixReq)))
	else
		reportError($sformatf("pBus low %h in slot %0d", $sampled(pBus[15:0]),
			$sampled(tbSlot)));

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!romSlot(tbSlot) |->
		(pBus[23:16] == 8'(scheduleWord(tbSlot, spriteReq, fixReq) >> 16)))
	else
		reportError($sformatf("pBus high %h in slot %0d", $sampled(pBus[23:16]),
			$sampled(tbSlot)));

	// ROM byte only, a clash shows up as X
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		romSlot(tbSlot) |-> (!$isunknown(pBus[23:16])
		&& (pBus[23:16] == (spriteReq.l0RomAddr[7:0] ^ 8'hA5))))
	else
		reportError($sformatf("released byte %h in slot %0d", $sampled(pBus[23:16]),
			$sampled(tbSlot)));

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		(int'(tbSlot) > 3 + ROM_LAT) |-> (l0Data == (spriteReq.l0RomAddr[7:0] ^ 8'hA5)))
	else
		reportError($sformatf("l0Data %h in slot %0d", $sampled(l0Data), $sampled(tbSlot)));

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		(tbSlot >= 4'd14) |-> (fixOut == {fixReq.fixPal, fixAt13[3:0], fixAt13[7:4]}))
	else
		reportError($sformatf("fixOut %h in slot %0d", $sampled(fixOut), $sampled(tbSlot)));

	// Mode 0 holds, 1 randomizes, 2 picks all zeros or all ones
	task automatic newRequests(input int mode);
		logic allOnes;
		allOnes = $urandom & 1;
		if (mode == 1)
		begin
			spriteReq.cRomAddr  = 25'($urandom);
			spriteReq.sprPal    = 8'($urandom);
			spriteReq.sprXpos   = 8'($urandom);
			spriteReq.l0RomAddr = 16'($urandom);
			fixReq.sRomAddr     = 16'($urandom);
			fixReq.fixPal       = 4'($urandom);
		end
		else if (mode == 2)
		begin
			spriteReq = allOnes ? '1 : '0;
			fixReq    = allOnes ? '1 : '0;
		end
	endtask

	// New requests at each frame start
	task automatic runFrames(input int frames, input int mode);
		repeat (frames * 16)
		begin
			@(posedge CLK_24M);
			#5;
			if (tbSlot == 4'd0)
				newRequests(mode);
		end
	endtask

	task automatic finishTest(input string name);
		int newErrs;
		newErrs = errCount - startErrs;
		testsRun++;
		if (newErrs != 0)
			testsFailed++;
		$display("Test %0d %s: %s, %0d errors", testsRun, name,
			(newErrs == 0) ? "ok" : "failed", newErrs);
		startErrs = errCount;
	endtask

	initial
	begin
		void'($urandom(32'h32de));
		nRESET = 1'b0;
		newRequests(1);
		startErrs = 0;
		repeat (2) @(posedge CLK_24M);
		#5;
		nRESET = 1'b1;
		runFrames(1, 0);
		finishTest("reset");
		runFrames(4, 0);
		finishTest("strobes");
		runFrames(8, 1);
		finishTest("bus content");
		runFrames(6, 2);
		finishTest("upper byte release");
		runFrames(8, 1);
		finishTest("L0 readback");
		runFrames(8, 1);
		finishTest("fix latch");
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(LIMIT_NS);
		$display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/pBusPkg.sv
verilog/pCycle.sv
verilog/pBusMux.sv
verilog/fixPixelLatch.sv
verilog/pBusTop.sv
dv/pBusRomModel.sv
dv/pBusTb.sv

// ==== Bender.yml ====
package:
  name: pbus_sequencer

sources:
  - verilog/pBusPkg.sv
  - verilog/pCycle.sv
  - verilog/pBusMux.sv
  - verilog/fixPixelLatch.sv
  - verilog/pBusTop.sv
  - target: simulation
    files:
      - dv/pBusRomModel.sv
      - dv/pBusTb.sv
